/* src/dmaPkg.sv */
package dmaPkg;

	// channel count used when the top level is not overridden
	parameter int defNumChannels = 4;

	// transfer address, driven straight onto the address bus
	typedef logic [15:0] addrT;

	// word count, N gives N+1 transfers
	typedef logic [15:0] countT;

	// channel number
	typedef logic [1:0] chanIdxT;

	// one bit per channel
	// used for requests, armed flags and acknowledges
	typedef logic [3:0] chanVecT;

	// transfer states
	// SI idle, SO waiting for hold acknowledge
	// S1 address strobe, S2 and S4 acknowledge cycles
	typedef enum logic [2:0] {
		stateSI,
		stateSO,
		stateS1,
		stateS2,
		stateS4
	} timingStateT;

	// resolver result
	// valid means at least one armed channel is requesting
	typedef struct packed {
		logic valid;
		chanIdxT channel;
	} grantT;

	// what the timing controller is doing right now
	// active covers SO through S4
	// done marks S4, the last cycle of a transfer
	typedef struct packed {
		logic active;
		logic done;
		chanIdxT channel;
	} serviceT;

endpackage

/* src/dmaRegPkg.sv */
package dmaRegPkg;

	// cpu register address
	typedef logic [3:0] regAddrT;

	// one register byte
	typedef logic [7:0] byteT;

	// channel area 0..7
	// bits 2:1 channel, bit 0 address (0) or word count (1)
	localparam regAddrT addrChanBase = 4'd0;
	// write goes to command, read returns status
	localparam regAddrT addrCommand = 4'd8;
	// any write clears the byte pointer
	localparam regAddrT addrClearPointer = 4'd12;

	// command byte
	// reserved bits are stored and read back as written
	typedef struct packed {
		logic [2:0] reservedHigh;
		logic rotatingPriority;
		logic reservedMid;
		logic controllerDisable;
		logic [1:0] reservedLow;
	} commandT;

	// status byte
	typedef struct packed {
		logic [3:0] requestPending;
		logic [3:0] terminalCount;
	} statusT;

	// cpu request, held by the cpu until accepted
	typedef struct packed {
		logic valid;
		logic write;
		regAddrT address;
		byteT writeData;
	} regReqT;

	// read return, valid for one cycle
	typedef struct packed {
		logic valid;
		byteT readData;
	} regRspT;

endpackage

/* src/dmaChannelRegs.sv */
`timescale 1ns/1ns

module dmaChannelRegs #(
	parameter int numChannels = 4
) (
	input logic busIf,
	input logic rst,
	input dmaRegPkg::regReqT regReq,
	input logic regReady,
	input dmaPkg::chanVecT dreq,
	input dmaPkg::serviceT service,
	output dmaRegPkg::regRspT regRsp,
	output dmaPkg::chanVecT armed,
	output dmaRegPkg::commandT command,
	output dmaPkg::addrT serviceAddr
);

	// per-channel current address and word count
	dmaPkg::addrT currentAddr [numChannels];
	dmaPkg::countT currentCount [numChannels];

	// sticky terminal count flags, cleared by a status read
	dmaPkg::chanVecT terminalCount;

	// byte pointer, 0 low byte, 1 high byte
	logic bytePointer;

	// request decode
	logic accept;
	logic chanAccess;
	logic chanWrite;
	logic commandWrite;
	logic statusRead;
	logic pointerClear;
	dmaPkg::chanIdxT regChan;

	dmaRegPkg::byteT chanByte;
	dmaRegPkg::byteT readByte;
	dmaRegPkg::statusT status;

	// handshake completes on valid and ready together
	assign accept = regReq.valid & regReady;
	// low three bits select inside the channel area
	assign chanAccess = accept && ({regReq.address[3], 3'b000} == dmaRegPkg::addrChanBase);
	assign chanWrite = chanAccess & regReq.write;
	assign commandWrite = accept & regReq.write & (regReq.address == dmaRegPkg::addrCommand);
	assign statusRead = accept & ~regReq.write & (regReq.address == dmaRegPkg::addrCommand);
	assign pointerClear = accept & regReq.write & (regReq.address == dmaRegPkg::addrClearPointer);
	assign regChan = regReq.address[2:1];

	// status shows raw requests next to the tc flags
	assign status.requestPending = dreq;
	assign status.terminalCount = terminalCount;

	// address of the channel under service, for the timing controller
	assign serviceAddr = currentAddr[service.channel];

	// byte picked by the pointer
	always_comb
	begin
		if (regReq.address[0])
			chanByte = bytePointer ? currentCount[regChan][15:8] : currentCount[regChan][7:0];
		else
			chanByte = bytePointer ? currentAddr[regChan][15:8] : currentAddr[regChan][7:0];
	end

	// read data mux, unmapped addresses return zero
	assign readByte = chanAccess ? chanByte :
		statusRead ? dmaRegPkg::byteT'(status) : '0;

	always_ff @(posedge busIf)
	begin
		if (rst)
		begin
			for (int i = 0; i < numChannels; i++)
			begin
				currentAddr[i] <= '0;
				currentCount[i] <= '0;
			end
			armed <= '0;
			command <= '0;
			terminalCount <= '0;
			bytePointer <= 1'b0;
			regRsp <= '0;
		end
		else
		begin
			// response one cycle after an accepted read
			regRsp.valid <= accept & ~regReq.write;
			if (accept && !regReq.write)
				regRsp.readData <= readByte;

			// pointer toggles on every channel access, low byte first
			if (pointerClear)
				bytePointer <= 1'b0;
			else if (chanAccess)
				bytePointer <= ~bytePointer;

			if (commandWrite)
				command <= dmaRegPkg::commandT'(regReq.writeData);

			// byte load into address or count
			if (chanWrite && !regReq.address[0] && !bytePointer)
				currentAddr[regChan][7:0] <= regReq.writeData;
			if (chanWrite && !regReq.address[0] && bytePointer)
				currentAddr[regChan][15:8] <= regReq.writeData;
			if (chanWrite && regReq.address[0] && !bytePointer)
				currentCount[regChan][7:0] <= regReq.writeData;
			// high count byte completes programming and arms the channel
			if (chanWrite && regReq.address[0] && bytePointer)
			begin
				currentCount[regChan][15:8] <= regReq.writeData;
				armed[regChan] <= 1'b1;
			end

			if (statusRead)
				terminalCount <= '0;

			// end of transfer, regReady is low here so no cpu access overlaps
			if (service.done)
			begin
				currentAddr[service.channel] <= currentAddr[service.channel] + 16'd1;
				if (currentCount[service.channel] == '0)
				begin
					// terminal count ends service until the count is rewritten
					terminalCount[service.channel] <= 1'b1;
					armed[service.channel] <= 1'b0;
				end
				else
					currentCount[service.channel] <= currentCount[service.channel] - 16'd1;
			end
		end
	end

endmodule

/* src/dmaPriority.sv */
`timescale 1ns/1ns

module dmaPriority #(
	parameter int numChannels = 4
) (
	input logic busIf,
	input logic rst,
	input dmaPkg::chanVecT dreq,
	input dmaPkg::chanVecT armed,
	input dmaRegPkg::commandT command,
	input dmaPkg::serviceT service,
	output dmaPkg::grantT grant
);

	// only armed channels compete
	dmaPkg::chanVecT pending;
	// highest priority channel in rotating mode
	dmaPkg::chanIdxT startPtr;

	// no new grant while a transfer is running
	assign pending = (dreq & armed) & {4{~service.active}};

	// scan from the start channel and take the first request found
	// fixed mode always starts at channel 0
	always_comb
	begin
		int idx;
		dmaPkg::chanIdxT base;
		grant = '0;
		base = command.rotatingPriority ? startPtr : '0;
		for (int off = 0; off < numChannels; off++)
		begin
			idx = (int'(base) + off) % numChannels;
			if (!grant.valid && pending[idx])
			begin
				grant.valid = 1'b1;
				grant.channel = dmaPkg::chanIdxT'(idx);
			end
		end
	end

	// serviced channel drops to lowest priority
	// fixed mode ignores the pointer and keeps channel 0 on top
	always_ff @(posedge busIf)
	begin
		if (rst)
			startPtr <= '0;
		else if (service.done)
			startPtr <= dmaPkg::chanIdxT'((int'(service.channel) + 1) % numChannels);
	end

endmodule

/* src/dmaTiming.sv */
`timescale 1ns/1ns

module dmaTiming (
	input logic busIf,
	input logic rst,
	input dmaPkg::grantT grant,
	input dmaRegPkg::commandT command,
	input logic hlda,
	input dmaPkg::addrT serviceAddr,
	output dmaPkg::serviceT service,
	output logic regReady,
	output logic hrq,
	output logic aen,
	output logic adstb,
	output dmaPkg::chanVecT dack,
	output dmaPkg::addrT dmaAddr
);

	dmaPkg::timingStateT state;
	dmaPkg::timingStateT nextState;

	// channel taken from the grant in SI
	dmaPkg::chanIdxT channel;

	// next state
	always_comb
	begin
		nextState = state;
		case (state)
			dmaPkg::stateSI:
			begin
				// disabled controller ignores requests
				if (grant.valid && !command.controllerDisable)
					nextState = dmaPkg::stateSO;
			end
			dmaPkg::stateSO:
			begin
				// hold here until the cpu releases the bus
				if (hlda)
					nextState = dmaPkg::stateS1;
			end
			dmaPkg::stateS1:
				nextState = dmaPkg::stateS2;
			dmaPkg::stateS2:
				nextState = dmaPkg::stateS4;
			dmaPkg::stateS4:
				nextState = dmaPkg::stateSI;
			default:
				nextState = dmaPkg::stateSI;
		endcase
	end

	always_ff @(posedge busIf)
	begin
		if (rst)
		begin
			state <= dmaPkg::stateSI;
			channel <= '0;
		end
		else
		begin
			state <= nextState;
			// latch the winner as we leave SI
			if (state == dmaPkg::stateSI && nextState == dmaPkg::stateSO)
				channel <= grant.channel;
		end
	end

	// address is captured on the SO to S1 edge so it is valid through S1..S4
	// serviceAddr already points at the latched channel during SO
	always_ff @(posedge busIf)
	begin
		if (state == dmaPkg::stateSO && hlda)
			dmaAddr <= serviceAddr;
	end

	// status for the register bank and the resolver
	assign service.active = (state != dmaPkg::stateSI);
	assign service.done = (state == dmaPkg::stateS4);
	assign service.channel = channel;

	// cpu access only while idle
	assign regReady = (state == dmaPkg::stateSI);

	// bus control decoded from state
	assign hrq = (state != dmaPkg::stateSI);
	assign aen = (state == dmaPkg::stateS1) || (state == dmaPkg::stateS2) ||
		(state == dmaPkg::stateS4);
	// strobe for one cycle
	assign adstb = (state == dmaPkg::stateS1);
	// acknowledge for two cycles, one-hot
	assign dack = ((state == dmaPkg::stateS2) || (state == dmaPkg::stateS4)) ?
		dmaPkg::chanVecT'(1) << channel : '0;

endmodule

/* src/dmaTop.sv */
`timescale 1ns/1ns

module dmaTop #(
	parameter int numChannels = dmaPkg::defNumChannels
) (
	input logic busIf,
	input logic rst,
	// cpu register port
	input dmaRegPkg::regReqT regReq,
	output logic regReady,
	output dmaRegPkg::regRspT regRsp,
	// dma side
	input dmaPkg::chanVecT dreq,
	input logic hlda,
	output logic hrq,
	output logic aen,
	output logic adstb,
	output dmaPkg::chanVecT dack,
	output dmaPkg::addrT dmaAddr
);

	dmaPkg::chanVecT armed;
	dmaRegPkg::commandT command;
	dmaPkg::grantT grant;
	dmaPkg::serviceT service;
	dmaPkg::addrT serviceAddr;

	// registers, address and count update at end of transfer
	dmaChannelRegs #(
		.numChannels(numChannels)
	) regs0 (
		.busIf(busIf),
		.rst(rst),
		.regReq(regReq),
		.regReady(regReady),
		.dreq(dreq),
		.service(service),
		.regRsp(regRsp),
		.armed(armed),
		.command(command),
		.serviceAddr(serviceAddr)
	);

	// picks the channel to serve next
	dmaPriority #(
		.numChannels(numChannels)
	) prio0 (
		.busIf(busIf),
		.rst(rst),
		.dreq(dreq),
		.armed(armed),
		.command(command),
		.service(service),
		.grant(grant)
	);

	// transfer sequencing and bus control
	dmaTiming timing0 (
		.busIf(busIf),
		.rst(rst),
		.grant(grant),
		.command(command),
		.hlda(hlda),
		.serviceAddr(serviceAddr),
		.service(service),
		.regReady(regReady),
		.hrq(hrq),
		.aen(aen),
		.adstb(adstb),
		.dack(dack),
		.dmaAddr(dmaAddr)
	);

endmodule

/* verification/dmaTop_checker.sv */
`timescale 1ns/1ns

module dmaTopChecker (
	input logic busIf,
	input logic rst,
	input logic regReady,
	input logic hrq,
	input logic aen,
	input logic adstb,
	input dmaPkg::chanVecT dack
);

	// number of failed assertions
	int failCount = 0;

	// address strobe is a one cycle pulse
	strobeOneCycle: assert property (@(posedge busIf) disable iff (rst) adstb |=> !adstb)
	else
	begin
		failCount++;
		$error("adstb high for more than one cycle");
	end

	// at most one acknowledge, and only with the address enabled
	ackOneHot: assert property (@(posedge busIf) disable iff (rst)
		$onehot0(dack) && ((dack == '0) || aen))
	else
	begin
		failCount++;
		$error("dack not one-hot or active without aen");
	end

	// address enable only while holding the bus
	aenNeedsHrq: assert property (@(posedge busIf) disable iff (rst) aen |-> hrq)
	else
	begin
		failCount++;
		$error("aen high without hrq");
	end

	// cpu port closed during a transfer
	readyIdleOnly: assert property (@(posedge busIf) disable iff (rst) hrq |-> !regReady)
	else
	begin
		failCount++;
		$error("regReady high while hrq high");
	end

endmodule

bind dmaTop dmaTopChecker checker0 (
	.busIf(busIf),
	.rst(rst),
	.regReady(regReady),
	.hrq(hrq),
	.aen(aen),
	.adstb(adstb),
	.dack(dack)
);

/* verification/dmaTb.sv */
`timescale 1ns/1ns

module dmaTb;

	// wait limit in clock cycles for every handshake loop
	localparam int waitLimit = 50;

	logic busIf;
	logic rst;
	dmaRegPkg::regReqT regReq;
	logic regReady;
	dmaRegPkg::regRspT regRsp;
	dmaPkg::chanVecT dreq;
	logic hlda;
	logic hrq;
	logic aen;
	logic adstb;
	dmaPkg::chanVecT dack;
	dmaPkg::addrT dmaAddr;

	int errorCount = 0;
	int checkCount = 0;
	int testCount = 0;
	int testStartErrors = 0;
	int totalErrors;
	logic [31:0] rngState = 32'h0d50d1c3;

	dmaTop #(
		.numChannels(dmaPkg::defNumChannels)
	) dut0 (
		.busIf(busIf),
		.rst(rst),
		.regReq(regReq),
		.regReady(regReady),
		.regRsp(regRsp),
		.dreq(dreq),
		.hlda(hlda),
		.hrq(hrq),
		.aen(aen),
		.adstb(adstb),
		.dack(dack),
		.dmaAddr(dmaAddr)
	);

	// 20 ns clock
	initial
	begin
		busIf = 1'b0;
		forever #10 busIf = ~busIf;
	end

	// xorshift32 step
	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic logic [31:0] nextRandom();
		rngState = xorshift(rngState);
		return rngState;
	endfunction

	// register address of a channel's address (0) or word count (1)
	function automatic dmaRegPkg::regAddrT chanAddr(input int ch, input int countSel);
		return dmaRegPkg::addrChanBase + dmaRegPkg::regAddrT'(2 * ch + countSel);
	endfunction

	task automatic checkBit(input string name, input logic got, input logic exp);
		checkCount++;
		if (got !== exp)
		begin
			errorCount++;
			$display("MISMATCH %0t %s got %b expected %b", $time, name, got, exp);
		end
	endtask

	task automatic checkByte(input string name, input dmaRegPkg::byteT got,
		input dmaRegPkg::byteT exp);
		checkCount++;
		if (got !== exp)
		begin
			errorCount++;
			$display("MISMATCH %0t %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	task automatic checkVec(input string name, input dmaPkg::chanVecT got,
		input dmaPkg::chanVecT exp);
		checkCount++;
		if (got !== exp)
		begin
			errorCount++;
			$display("MISMATCH %0t %s got %b expected %b", $time, name, got, exp);
		end
	endtask

	task automatic checkAddr(input string name, input dmaPkg::addrT got,
		input dmaPkg::addrT exp);
		checkCount++;
		if (got !== exp)
		begin
			errorCount++;
			$display("MISMATCH %0t %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	task automatic reportTimeout(input string what);
		errorCount++;
		$display("timeout at %0t while waiting for %s", $time, what);
	endtask

	// all tasks below start and end on a falling edge
	task automatic applyReset();
		@(negedge busIf);
		rst = 1'b1;
		regReq = '0;
		dreq = '0;
		hlda = 1'b0;
		repeat (4) @(negedge busIf);
		rst = 1'b0;
	endtask

	// regReq is already driven, wait for ready and drop valid after the accepting edge
	task automatic acceptRequest();
		int n;
		n = 0;
		while (!regReady && n < waitLimit)
		begin
			@(negedge busIf);
			n++;
		end
		if (!regReady)
			reportTimeout("regReady");
		@(posedge busIf);
		@(negedge busIf);
		regReq.valid = 1'b0;
	endtask

	task automatic regWrite(input dmaRegPkg::regAddrT address, input dmaRegPkg::byteT data);
		regReq = {1'b1, 1'b1, address, data};
		acceptRequest();
	endtask

	task automatic regRead(input dmaRegPkg::regAddrT address, output dmaRegPkg::byteT data);
		int n;
		regReq = {1'b1, 1'b0, address, 8'h00};
		acceptRequest();
		// response is registered on the accepting edge
		n = 0;
		while (!regRsp.valid && n < waitLimit)
		begin
			@(negedge busIf);
			n++;
		end
		if (!regRsp.valid)
			reportTimeout("regRsp.valid");
		data = regRsp.readData;
	endtask

	// byte pointer cleared first, then low and high byte
	task automatic programChannel(input int ch, input dmaPkg::addrT addr,
		input dmaPkg::countT count);
		regWrite(dmaRegPkg::addrClearPointer, 8'h00);
		regWrite(chanAddr(ch, 0), addr[7:0]);
		regWrite(chanAddr(ch, 0), addr[15:8]);
		regWrite(chanAddr(ch, 1), count[7:0]);
		// high count byte arms the channel
		regWrite(chanAddr(ch, 1), count[15:8]);
	endtask

	task automatic readWord(input dmaRegPkg::regAddrT address, output logic [15:0] word);
		dmaRegPkg::byteT lo;
		dmaRegPkg::byteT hi;
		regWrite(dmaRegPkg::addrClearPointer, 8'h00);
		regRead(address, lo);
		regRead(address, hi);
		word = {hi, lo};
	endtask

	// address sampled in S1, acknowledge in S2, returns once back in SI
	task automatic awaitTransfer(output dmaPkg::chanVecT ack, output dmaPkg::addrT addr);
		int n;
		n = 0;
		while (!adstb && n < waitLimit)
		begin
			@(negedge busIf);
			n++;
		end
		if (!adstb)
			reportTimeout("adstb");
		addr = dmaAddr;
		@(negedge busIf);
		ack = dack;
		n = 0;
		while (!regReady && n < waitLimit)
		begin
			@(negedge busIf);
			n++;
		end
		if (!regReady)
			reportTimeout("end of transfer");
	endtask

	task automatic startTest();
		testStartErrors = errorCount;
		applyReset();
	endtask

	task automatic finishTest(input string name);
		testCount++;
		$display("test %s finished with %0d errors", name, errorCount - testStartErrors);
	endtask

	task automatic testReset();
		dmaRegPkg::byteT data;
		startTest();
		checkBit("hrq", hrq, 1'b0);
		checkBit("aen", aen, 1'b0);
		checkBit("adstb", adstb, 1'b0);
		checkVec("dack", dack, 4'b0000);
		checkBit("regReady", regReady, 1'b1);
		checkBit("regRsp.valid", regRsp.valid, 1'b0);
		regRead(dmaRegPkg::addrCommand, data);
		checkByte("status", data, 8'h00);
		// two reads per register walk low then high byte
		for (int r = 0; r < 8; r++)
		begin
			for (int b = 0; b < 2; b++)
			begin
				regRead(dmaRegPkg::addrChanBase + dmaRegPkg::regAddrT'(r), data);
				checkByte("channel byte", data, 8'h00);
			end
		end
		finishTest("reset");
	endtask

	task automatic testProgramming();
		dmaPkg::addrT addrs [4];
		dmaPkg::countT counts [4];
		logic [15:0] word;
		dmaRegPkg::byteT data;
		startTest();
		for (int ch = 0; ch < 4; ch++)
		begin
			addrs[ch] = nextRandom() >> 8;
			counts[ch] = nextRandom() >> 8;
			programChannel(ch, addrs[ch], counts[ch]);
		end
		for (int ch = 0; ch < 4; ch++)
		begin
			readWord(chanAddr(ch, 0), word);
			checkAddr("address readback", word, addrs[ch]);
			readWord(chanAddr(ch, 1), word);
			checkAddr("count readback", word, counts[ch]);
		end
		// one read leaves the pointer on the high byte, clear puts it back
		regRead(chanAddr(0, 0), data);
		regWrite(dmaRegPkg::addrClearPointer, 8'h00);
		regRead(chanAddr(0, 0), data);
		checkByte("address low after clear", data, addrs[0][7:0]);
		finishTest("programming");
	endtask

	task automatic testFixedPriority();
		dmaPkg::addrT addrs [4];
		dmaPkg::chanVecT ack;
		dmaPkg::addrT addr;
		startTest();
		for (int ch = 1; ch < 4; ch++)
		begin
			addrs[ch] = nextRandom() >> 8;
			programChannel(ch, addrs[ch], 16'd5);
		end
		hlda = 1'b1;
		// channel 0 requests too but was never armed
		dreq = 4'b1111;
		// channel 1 keeps winning while it stays armed
		for (int t = 0; t < 2; t++)
		begin
			awaitTransfer(ack, addr);
			checkVec("dack", ack, 4'b0010);
			checkAddr("dmaAddr", addr, addrs[1] + dmaPkg::addrT'(t));
		end
		dreq = '0;
		finishTest("fixed priority");
	endtask

	task automatic testRotatingPriority();
		dmaRegPkg::commandT cmd;
		dmaPkg::addrT addrs [4];
		dmaPkg::chanVecT ack;
		dmaPkg::addrT addr;
		startTest();
		cmd = '0;
		cmd.rotatingPriority = 1'b1;
		regWrite(dmaRegPkg::addrCommand, dmaRegPkg::byteT'(cmd));
		for (int ch = 0; ch < 4; ch++)
		begin
			addrs[ch] = nextRandom() >> 8;
			programChannel(ch, addrs[ch], 16'd3);
		end
		hlda = 1'b1;
		dreq = 4'b1111;
		// serviced channel drops to lowest, so the order is 0 1 2 3
		for (int t = 0; t < 4; t++)
		begin
			awaitTransfer(ack, addr);
			checkVec("dack", ack, dmaPkg::chanVecT'(4'b0001 << t));
			checkAddr("dmaAddr", addr, addrs[t]);
		end
		dreq = '0;
		finishTest("rotating priority");
	endtask

	task automatic testTerminalCount();
		dmaPkg::addrT a;
		dmaPkg::chanVecT ack;
		dmaPkg::addrT addr;
		dmaRegPkg::statusT status;
		dmaRegPkg::byteT data;
		logic [15:0] word;
		startTest();
		a = nextRandom() >> 8;
		// count 1 gives two transfers
		programChannel(2, a, 16'd1);
		hlda = 1'b1;
		dreq = 4'b0100;
		for (int t = 0; t < 2; t++)
		begin
			awaitTransfer(ack, addr);
			checkVec("dack", ack, 4'b0100);
			checkAddr("dmaAddr", addr, a + dmaPkg::addrT'(t))	;
		end
		// request still high but the channel is disarmed
		for (int i = 0; i < 10; i++)
		begin
			@(negedge busIf);
			checkBit("hrq after terminal count", hrq, 1'b0);
		end
		status.requestPending = dreq;
		status.terminalCount = 4'b0100;
		regRead(dmaRegPkg::addrCommand, data);
		checkByte("status", data, dmaRegPkg::byteT'(status));
		readWord(chanAddr(2, 0), word);
		checkAddr("address after terminal count", word, a + 16'd2);
		// the first status read cleared the flag
		status.terminalCount = 4'b0000;
		regRead(dmaRegPkg::addrCommand, data);
		checkByte("status second read", data, dmaRegPkg::byteT'(status));
		dreq = '0;
		finishTest("terminal count");
	endtask

	task automatic testBackPressure();
		dmaPkg::addrT a;
		dmaRegPkg::byteT d;
		dmaRegPkg::byteT data;
		dmaPkg::chanVecT ack;
		dmaPkg::addrT addr;
		int n;
		startTest();
		a = nextRandom() >> 8;
		d = nextRandom() >> 24;
		programChannel(0, a, 16'd0);
		hlda = 1'b0;
		dreq = 4'b0001;
		n = 0;
		while (!hrq && n < waitLimit)
		begin
			@(negedge busIf);
			n++;
		end
		if (!hrq)
			reportTimeout("hrq");
		// write to channel 1 address low byte, held while the bus is not granted
		regReq = {1'b1, 1'b1, chanAddr(1, 0), d};
		for (int i = 0; i < 8; i++)
		begin
			@(negedge busIf);
			checkBit("hrq while hlda low", hrq, 1'b1);
			checkBit("aen while hlda low", aen, 1'b0);
			checkBit("adstb while hlda low", adstb, 1'b0);
			checkBit("regReady while hlda low", regReady, 1'b0);
		end
		hlda = 1'b1;
		awaitTransfer(ack, addr);
		checkVec("dack", ack, 4'b0001);
		checkAddr("dmaAddr", addr, a);
		// transfer done, the held write goes through now
		acceptRequest();
		dreq = '0;
		regWrite(dmaRegPkg::addrClearPointer, 8'h00);
		regRead(chanAddr(1, 0), data);
		checkByte("held write readback", data, d);
		finishTest("back-pressure");
	endtask

	initial
	begin
		rst = 1'b1;
		regReq = '0;
		dreq = '0;
		hlda = 1'b0;
		testReset();
		testProgramming();
		testFixedPriority();
		testRotatingPriority();
		testTerminalCount();
		testBackPressure();
		totalErrors = errorCount + dut0.checker0.failCount;
		$display("tests %0d, checks %0d, check errors %0d, assertion failures %0d",
			testCount, checkCount, errorCount, dut0.checker0.failCount);
		if (totalErrors == 0)
			$display("Done: no errors");
		else
			$display("Done: errors found");
		$finish;
	end

endmodule

/* src.f */
src/dmaPkg.sv
src/dmaRegPkg.sv
src/dmaChannelRegs.sv
src/dmaPriority.sv
src/dmaTiming.sv
src/dmaTop.sv
verification/dmaTop_checker.sv
verification/dmaTb.sv
